// File: verilog/stream_sync_pkg.sv
// shared types for the stream synchronizer; tuser is 16 bits and carries either a packet id or a header-last marker
`default_nettype none

package stream_sync_pkg;

   // ----------------------------------------------------------------------
   // synchronization mode and widths
   // ----------------------------------------------------------------------

   // sop aligns packet starts, hdr_tlast aligns the end of the header
   typedef enum logic [0:0] {
      SOP       = 1'b0,
      HDR_TLAST = 1'b1
   } sync_mode_t;

   localparam int DATA_W = 64;
   localparam int KEEP_W = DATA_W / 8;
   localparam int PTR_W  = 12;
   localparam int CNT_W  = 16;

   // ----------------------------------------------------------------------
   // buffer context carried in tuser
   // ----------------------------------------------------------------------

   // packet id view, the write pointer sits in the low bits
   typedef struct packed {
      logic [3:0]       spare;
      logic [PTR_W-1:0] wr_ptr;
   } sop_ctx_t;

   // header view, bit 0 marks the payload beat that lines up with the header tlast
   typedef struct packed {
      logic [14:0] spare;
      logic        hdr_tlast;
   } hdr_ctx_t;

   // the same 16 bit word is decoded one way or the other depending on the mode
   typedef union packed {
      sop_ctx_t sop;
      hdr_ctx_t hdr;
   } buffer_ctx_u;

   // one stream beat, 89 bits in all
   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic [KEEP_W-1:0] tkeep;
      logic              tlast;
      buffer_ctx_u       tuser;
   } stream_beat_t;

endpackage

`default_nettype wire

// File: verilog/sop_tracker.sv
// start-of-packet flag per stream; assumes every packet ends with a tlast beat, no explicit sop from the source
`timescale 1ns/1ps
`default_nettype none

module sop_tracker (
   input  logic clk,
   input  logic reset,
   input  logic xfer,
   input  logic tlast,
   output logic at_sop
);

   // ----------------------------------------------------------------------
   // packet boundary tracking
   // ----------------------------------------------------------------------

   // the flag answers one question: is the beat now waiting at the
   // input the first beat of a packet?
   // after reset the stream is idle, so the first beat seen is a start

   // a transfer of a last beat means the next beat opens a new packet
   // any other transfer means we are now inside a packet
   // without a transfer the flag keeps its value, since the beat
   // waiting at the input has not changed position in the packet

   always_ff @(posedge clk) begin
      if (reset) begin
         at_sop <= 1'b1;
      end else if (xfer) begin
         at_sop <= tlast;
      end
   end

   // note that xfer is the out-side transfer of the same stream, and
   // the gate forwards the beat unchanged, so the in-side and out-side
   // view of packet position are always identical

endmodule

`default_nettype wire

// File: verilog/sync_fsm.sv
// sync event detection and release tracking; a sop mismatch holds both streams with no recovery short of reset
`timescale 1ns/1ps
`default_nettype none

module sync_fsm #(
   parameter stream_sync_pkg::sync_mode_t MODE = stream_sync_pkg::SOP
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         valid_in_0,
   input  logic                         valid_in_1,
   input  stream_sync_pkg::stream_beat_t beat_in_0,
   input  stream_sync_pkg::stream_beat_t beat_in_1,
   input  logic                         at_sop_0,
   input  logic                         at_sop_1,
   input  logic                         xfer_0,
   input  logic                         xfer_1,
   output logic                         pass_0,
   output logic                         pass_1,
   output logic                         sync_pulse,
   output logic                         sop_mismatch,
   output logic                         mismatch_rise
);

   // bit n set means side n has been cleared past a sync but still
   // holds its event beat
   typedef enum logic [1:0] {
      ALIGN         = 2'b00,
      RELEASED_0    = 2'b01,
      RELEASED_1    = 2'b10,
      RELEASED_BOTH = 2'b11
   } state_t;

   state_t state, state_next;
   logic   evt_0, evt_1;
   logic   sync_cond, id_match, sync;
   logic   mismatch_q;

   // ----------------------------------------------------------------------
   // event decode
   // ----------------------------------------------------------------------

   // in hdr_tlast mode side 0 carries the header and side 1 the payload
   // whose context marks the beat that pairs with the header end
   assign evt_0 = (MODE == stream_sync_pkg::SOP) ? at_sop_0 : beat_in_0.tlast;
   assign evt_1 = (MODE == stream_sync_pkg::SOP) ? at_sop_1 : beat_in_1.tuser.hdr.hdr_tlast;

   assign id_match = (beat_in_0.tuser.sop.wr_ptr == beat_in_1.tuser.sop.wr_ptr);

   // a new sync is only taken once both earlier event beats are gone,
   // otherwise a short packet could pair with a stale beat on the other side
   assign sync_cond = (state == ALIGN) && valid_in_0 && evt_0 && valid_in_1 && evt_1;
   assign sync      = sync_cond && ((MODE == stream_sync_pkg::HDR_TLAST) || id_match);

   assign sop_mismatch = (MODE == stream_sync_pkg::SOP) && sync_cond && !id_match;

   // ----------------------------------------------------------------------
   // pass rule
   // ----------------------------------------------------------------------

   assign pass_0 = !evt_0 || sync || state[0];
   assign pass_1 = !evt_1 || sync || state[1];

   assign sync_pulse    = sync;
   assign mismatch_rise = sop_mismatch && !mismatch_q;

   // ----------------------------------------------------------------------
   // release state
   // ----------------------------------------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         ALIGN: begin
            // a side that moves its event beat on the sync edge needs no release
            if (sync) begin
               state_next = state_t'({!xfer_1, !xfer_0});
            end
         end
         RELEASED_0: begin
            if (xfer_0) state_next = ALIGN;
         end
         RELEASED_1: begin
            if (xfer_1) state_next = ALIGN;
         end
         RELEASED_BOTH: begin
            state_next = state_t'({!xfer_1, !xfer_0});
         end
         default: state_next = ALIGN;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ALIGN;
         mismatch_q <= 1'b0;
      end else begin
         state      <= state_next;
         mismatch_q <= sop_mismatch;
      end
   end

endmodule

`default_nettype wire

// File: verilog/sync_event_counter.sv
// status counters for syncs and mismatches; they saturate at all ones and clear only on reset
`timescale 1ns/1ps
`default_nettype none

module sync_event_counter #(
   parameter int CNT_W = 16
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             sync_pulse,
   input  logic             mismatch_rise,
   output logic [CNT_W-1:0] sync_count,
   output logic [CNT_W-1:0] mismatch_count
);

   // ----------------------------------------------------------------------
   // saturating increment
   // ----------------------------------------------------------------------

   // once the count is all ones it stays there, so a reader can tell
   // that events were lost instead of seeing a wrapped small value
   function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] value);
      if (&value) begin
         return value;
      end
      return value + 1'b1;
   endfunction

   // both inputs are single cycle pulses, so each event counts once
   // and the new value shows up the cycle after the event
   always_ff @(posedge clk) begin
      if (reset) begin
         sync_count     <= '0;
         mismatch_count <= '0;
      end else begin
         if (sync_pulse) begin
            sync_count <= sat_inc(sync_count);
         end
         if (mismatch_rise) begin
            mismatch_count <= sat_inc(mismatch_count);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/stream_gate.sv
// valid/ready gate for one stream; purely combinational, so ready_in depends on ready_out in the same cycle
`timescale 1ns/1ps
`default_nettype none

module stream_gate (
   input  logic                          valid_in,
   input  stream_sync_pkg::stream_beat_t beat_in,
   output logic                          ready_in,
   output logic                          valid_out,
   output stream_sync_pkg::stream_beat_t beat_out,
   input  logic                          ready_out,
   input  logic                          pass,
   output logic                          xfer
);

   // ----------------------------------------------------------------------
   // handshake gating
   // ----------------------------------------------------------------------

   // while pass is low the beat is hidden from the consumer and the
   // source sees no ready, so the beat simply waits at the input
   assign valid_out = valid_in && pass;
   assign ready_in  = ready_out && pass;

   // the payload goes through untouched, only the handshake is gated
   assign beat_out = beat_in;

   // out-side transfer, which equals the in-side transfer here
   assign xfer = valid_out && ready_out;

endmodule

`default_nettype wire

// File: verilog/stream_sync.sv
// two-stream synchronizer, single clock; in hdr_tlast mode side 0 must carry the header and side 1 the payload
`timescale 1ns/1ps
`default_nettype none

module stream_sync #(
   parameter stream_sync_pkg::sync_mode_t MODE  = stream_sync_pkg::SOP,
   parameter int                          CNT_W = stream_sync_pkg::CNT_W
) (
   input  logic                          axi4s_in0,
   input  logic                          reset,
   // side 0
   input  stream_sync_pkg::stream_beat_t beat_in_0,
   input  logic                          valid_in_0,
   output logic                          ready_in_0,
   output stream_sync_pkg::stream_beat_t beat_out_0,
   output logic                          valid_out_0,
   input  logic                          ready_out_0,
   // side 1
   input  stream_sync_pkg::stream_beat_t beat_in_1,
   input  logic                          valid_in_1,
   output logic                          ready_in_1,
   output stream_sync_pkg::stream_beat_t beat_out_1,
   output logic                          valid_out_1,
   input  logic                          ready_out_1,
   // status
   output logic                          sop_mismatch,
   output logic [CNT_W-1:0]              sync_count,
   output logic [CNT_W-1:0]              mismatch_count
);

   logic at_sop_0, at_sop_1;
   logic pass_0, pass_1;
   logic xfer_0, xfer_1;
   logic sync_pulse, mismatch_rise;

   // ----------------------------------------------------------------------
   // per-stream packet position
   // ----------------------------------------------------------------------

   sop_tracker u_sop_tracker_0 (.clk(axi4s_in0), .reset(reset), .xfer(xfer_0),
      .tlast(beat_out_0.tlast), .at_sop(at_sop_0));

   sop_tracker u_sop_tracker_1 (.clk(axi4s_in0), .reset(reset), .xfer(xfer_1),
      .tlast(beat_out_1.tlast), .at_sop(at_sop_1));

   // ----------------------------------------------------------------------
   // event detection and stall control
   // ----------------------------------------------------------------------

   sync_fsm #(.MODE(MODE)) u_sync_fsm (
      .clk(axi4s_in0), .reset(reset),
      .valid_in_0(valid_in_0), .valid_in_1(valid_in_1),
      .beat_in_0(beat_in_0), .beat_in_1(beat_in_1),
      .at_sop_0(at_sop_0), .at_sop_1(at_sop_1),
      .xfer_0(xfer_0), .xfer_1(xfer_1),
      .pass_0(pass_0), .pass_1(pass_1),
      .sync_pulse(sync_pulse), .sop_mismatch(sop_mismatch),
      .mismatch_rise(mismatch_rise));

   // ----------------------------------------------------------------------
   // datapath gates and status
   // ----------------------------------------------------------------------

   stream_gate u_stream_gate_0 (.valid_in(valid_in_0), .beat_in(beat_in_0),
      .ready_in(ready_in_0), .valid_out(valid_out_0), .beat_out(beat_out_0),
      .ready_out(ready_out_0), .pass(pass_0), .xfer(xfer_0));

   stream_gate u_stream_gate_1 (.valid_in(valid_in_1), .beat_in(beat_in_1),
      .ready_in(ready_in_1), .valid_out(valid_out_1), .beat_out(beat_out_1),
      .ready_out(ready_out_1), .pass(pass_1), .xfer(xfer_1));

   sync_event_counter #(.CNT_W(CNT_W)) u_sync_event_counter (
      .clk(axi4s_in0), .reset(reset),
      .sync_pulse(sync_pulse), .mismatch_rise(mismatch_rise),
      .sync_count(sync_count), .mismatch_count(mismatch_count));

endmodule

`default_nettype wire

// File: sim/stream_sync_assertions.sv
// bound protocol and stall checks for stream_sync; the alignment rule is only checked in sop mode
`timescale 1ns/1ps
`default_nettype none

module stream_sync_assertions #(
   parameter stream_sync_pkg::sync_mode_t MODE = stream_sync_pkg::SOP
) (
   input logic                          clk,
   input logic                          reset,
   input logic                          valid_in_0,
   input logic                          valid_in_1,
   input logic                          valid_out_0,
   input logic                          valid_out_1,
   input logic                          ready_out_0,
   input logic                          ready_out_1,
   input stream_sync_pkg::stream_beat_t beat_out_0,
   input stream_sync_pkg::stream_beat_t beat_out_1,
   input logic                          at_sop_0,
   input logic                          at_sop_1,
   input logic [1:0]                    released,
   input logic                          sop_mismatch
);

   // number of failed checks so far
   int unsigned fail_cnt = 0;

   // ----------------------------------------------------------------------
   // out-side protocol
   // ----------------------------------------------------------------------

   // a beat shown to the consumer stays shown and unchanged until taken
   a_hold_0: assert property (@(posedge clk) disable iff (reset)
      valid_out_0 && !ready_out_0 |=> valid_out_0 && $stable(beat_out_0))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("side 0 out beat dropped or changed before its transfer");
      end
   a_hold_1: assert property (@(posedge clk) disable iff (reset)
      valid_out_1 && !ready_out_1 |=> valid_out_1 && $stable(beat_out_1))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("side 1 out beat dropped or changed before its transfer");
      end

   // ----------------------------------------------------------------------
   // stall rules
   // ----------------------------------------------------------------------

   // a first beat only moves when the other side offers one too, or
   // when its own side was already released by an earlier sync
   a_align_0: assert property (@(posedge clk) disable iff (reset)
      (MODE == stream_sync_pkg::SOP) && valid_out_0 && ready_out_0 && at_sop_0
      |-> valid_in_1 || released[0])
      else begin
         fail_cnt = fail_cnt + 1;
         $error("side 0 first beat moved without side 1 being at its first beat");
      end
   a_align_1: assert property (@(posedge clk) disable iff (reset)
      (MODE == stream_sync_pkg::SOP) && valid_out_1 && ready_out_1 && at_sop_1
      |-> valid_in_0 || released[1])
      else begin
         fail_cnt = fail_cnt + 1;
         $error("side 1 first beat moved without side 0 being at its first beat");
      end

   // differing ids keep both streams hidden from the consumers
   a_mismatch_hold: assert property (@(posedge clk) disable iff (reset)
      sop_mismatch |-> !valid_out_0 && !valid_out_1)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("a stream was offered while the packet ids differ");
      end

endmodule

bind stream_sync stream_sync_assertions #(.MODE(MODE)) u_assertions (
   .clk(axi4s_in0), .reset(reset),
   .valid_in_0(valid_in_0), .valid_in_1(valid_in_1),
   .valid_out_0(valid_out_0), .valid_out_1(valid_out_1),
   .ready_out_0(ready_out_0), .ready_out_1(ready_out_1),
   .beat_out_0(beat_out_0), .beat_out_1(beat_out_1),
   .at_sop_0(at_sop_0), .at_sop_1(at_sop_1),
   .released(u_sync_fsm.state), .sop_mismatch(sop_mismatch));

`default_nettype wire

// File: sim/stream_sync_tb.sv
// testbench for stream_sync; sop mode by default, set TB_MODE for hdr_tlast; in sop mode the bad row ends the run
`timescale 1ns/1ps
`default_nettype none

module stream_sync_tb #(
   parameter stream_sync_pkg::sync_mode_t TB_MODE = stream_sync_pkg::SOP
);

   // one packet pair per row where bad gives side 1 a different packet id
   typedef struct packed {
      logic [7:0]  len_0;
      logic [7:0]  len_1;
      logic [11:0] id;
      logic        bad;
   } pkt_row_t;

   localparam int NROWS = 6;
   localparam int LIMIT = 1000;

   pkt_row_t rows [NROWS] = '{'{8'd3, 8'd2, 12'h010, 1'b0}, '{8'd1, 8'd4, 12'h011, 1'b0},
      '{8'd5, 8'd1, 12'h012, 1'b0}, '{8'd2, 8'd2, 12'h013, 1'b0},
      '{8'd4, 8'd3, 12'h014, 1'b0}, '{8'd2, 8'd3, 12'h0aa, 1'b1}};

   logic axi4s_in0 = 1'b0;
   logic reset, valid_in_0, valid_in_1, ready_in_0, ready_in_1;
   logic valid_out_0, valid_out_1, ready_out_0, ready_out_1, sop_mismatch;
   logic [15:0] sync_count, mismatch_count;
   logic [31:0] lfsr = 32'he1ef_0b5b;
   stream_sync_pkg::stream_beat_t beat_in_0, beat_in_1, beat_out_0, beat_out_1;

   // expected out beats per side with a flag for the sync event beat
   stream_sync_pkg::stream_beat_t exp_beat [2][64];
   logic exp_evt [2][64];
   int exp_len [2] = '{0, 0};
   int rd_ptr [2] = '{0, 0};
   int evt_cnt [2] = '{0, 0};

   always #5 axi4s_in0 = ~axi4s_in0;

   stream_sync #(.MODE(TB_MODE)) dut (.axi4s_in0(axi4s_in0), .reset(reset),
      .beat_in_0(beat_in_0), .valid_in_0(valid_in_0), .ready_in_0(ready_in_0),
      .beat_out_0(beat_out_0), .valid_out_0(valid_out_0), .ready_out_0(ready_out_0),
      .beat_in_1(beat_in_1), .valid_in_1(valid_in_1), .ready_in_1(ready_in_1),
      .beat_out_1(beat_out_1), .valid_out_1(valid_out_1), .ready_out_1(ready_out_1),
      .sop_mismatch(sop_mismatch), .sync_count(sync_count), .mismatch_count(mismatch_count));

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------

   // fibonacci lfsr with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic stop_row(input int row);
      return (TB_MODE == stream_sync_pkg::SOP) && rows[row].bad;
   endfunction

   // the event is the first beat in sop mode, and in hdr_tlast mode the
   // header last beat or the middle payload beat
   function automatic logic is_event(input int side, input int row, input int i);
      if (TB_MODE == stream_sync_pkg::SOP) return i == 0;
      if (side == 0) return i == rows[row].len_0 - 1;
      return i == rows[row].len_1 / 2;
   endfunction

   function automatic stream_sync_pkg::stream_beat_t make_beat(input int side, input int row,
      input int i);
      stream_sync_pkg::stream_beat_t b;
      int len;
      b = '0;
      len = (side == 0) ? rows[row].len_0 : rows[row].len_1;
      b.tdata = {16'(side), 16'(row), 32'(i) ^ 32'h5a5a_3c3c};
      b.tlast = (i == len - 1);
      b.tkeep = b.tlast ? 8'h0f : 8'hff;
      if (TB_MODE == stream_sync_pkg::SOP)
         b.tuser.sop.wr_ptr = (side == 0) ? rows[row].id : rows[row].id ^ {11'd0, rows[row].bad};
      else
         b.tuser.hdr.hdr_tlast = (side == 1) && is_event(side, row, i);
      return b;
   endfunction

   function automatic logic in_ready(input int side);
      return (side == 0) ? ready_in_0 : ready_in_1;
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic drive_beat(input int side, input stream_sync_pkg::stream_beat_t b,
      input logic v);
      if (side == 0) begin
         beat_in_0 = b;
         valid_in_0 = v;
      end else begin
         beat_in_1 = b;
         valid_in_1 = v;
      end
   endtask

   // the source for one side walks the whole table and holds each beat until accepted
   task automatic send_side(input int side);
      int row, i, len, wait_cnt;
      for (row = 0; row < NROWS; row++) begin
         len = (side == 0) ? rows[row].len_0 : rows[row].len_1;
         for (i = 0; i < len; i++) begin
            @(negedge axi4s_in0);
            drive_beat(side, make_beat(side, row, i), 1'b1);
            // the bad row leaves its first beat on offer for the stall check
            if (stop_row(row)) return;
            wait_cnt = 0;
            do begin
               @(posedge axi4s_in0);
               wait_cnt++;
            end while (!in_ready(side) && wait_cnt < LIMIT);
            assert (in_ready(side)) else stop_with_error($sformatf(
               "timeout: side %0d beat %0d of row %0d was never accepted", side, i, row));
         end
      end
      @(negedge axi4s_in0);
      drive_beat(side, '0, 1'b0);
   endtask

   // ----------------------------------------------------------------------
   // back-pressure and scoreboards
   // ----------------------------------------------------------------------

   always @(negedge axi4s_in0) begin
      lfsr = lfsr_step(lfsr);
      ready_out_0 = lfsr[0];
      lfsr = lfsr_step(lfsr);
      ready_out_1 = lfsr[0];
   end

   task automatic check_beat(input int side, input stream_sync_pkg::stream_beat_t got);
      stream_sync_pkg::stream_beat_t want;
      assert (rd_ptr[side] < exp_len[side]) else
         stop_with_error($sformatf("side %0d sent a beat beyond the expected stream", side));
      want = exp_beat[side][rd_ptr[side]];
      assert (got === want) else stop_with_error($sformatf(
         "MISMATCH time %0t beat_out_%0d got %h expected %h", $time, side, got, want));
      // an event beat may only leave once the other side reached the same event
      if (exp_evt[side][rd_ptr[side]]) begin
         assert (evt_cnt[1 - side] >= evt_cnt[side]) else stop_with_error($sformatf(
            "side %0d passed sync event %0d before the other side", side, evt_cnt[side]));
         evt_cnt[side]++;
      end
      rd_ptr[side]++;
   endtask

   always @(posedge axi4s_in0) begin
      if (!reset && valid_out_0 && ready_out_0) check_beat(0, beat_out_0);
      if (!reset && valid_out_1 && ready_out_1) check_beat(1, beat_out_1);
   end

   // the bound checker counts its failed assertions
   always @(dut.u_assertions.fail_cnt) begin
      assert (dut.u_assertions.fail_cnt == 0) else
         stop_with_error("a bound protocol or stall assertion failed");
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------

   initial begin : main
      int row, side, i, len, wait_cnt, n_sync;
      reset = 1'b1;
      ready_out_0 = 1'b0;
      ready_out_1 = 1'b0;
      drive_beat(0, '0, 1'b0);
      drive_beat(1, '0, 1'b0);
      n_sync = 0;
      for (row = 0; row < NROWS && !stop_row(row); row++) begin
         n_sync++;
         for (side = 0; side < 2; side++) begin
            len = (side == 0) ? rows[row].len_0 : rows[row].len_1;
            for (i = 0; i < len; i++) begin
               exp_beat[side][exp_len[side]] = make_beat(side, row, i);
               exp_evt[side][exp_len[side]] = is_event(side, row, i);
               exp_len[side]++;
            end
         end
      end
      repeat (16) @(posedge axi4s_in0);
      @(negedge axi4s_in0);
      reset = 1'b0;
      assert (sync_count == 0) else stop_with_error($sformatf(
         "MISMATCH time %0t sync_count got %0d expected 0", $time, sync_count));
      assert (mismatch_count == 0) else stop_with_error($sformatf(
         "MISMATCH time %0t mismatch_count got %0d expected 0", $time, mismatch_count));
      fork
         send_side(0);
         send_side(1);
      join
      assert (rd_ptr[0] == exp_len[0] && rd_ptr[1] == exp_len[1]) else
         stop_with_error("not every expected beat reached the out ports");
      wait_cnt = 0;
      while (sync_count != n_sync && wait_cnt < 50) begin
         @(posedge axi4s_in0);
         wait_cnt++;
      end
      assert (sync_count == n_sync) else stop_with_error($sformatf(
         "MISMATCH time %0t sync_count got %0d expected %0d", $time, sync_count, n_sync));
      if (TB_MODE == stream_sync_pkg::SOP) begin
         wait_cnt = 0;
         while (!sop_mismatch && wait_cnt < LIMIT) begin
            @(posedge axi4s_in0);
            wait_cnt++;
         end
         assert (sop_mismatch) else stop_with_error("sop_mismatch never rose for differing ids");
         // both first beats must stay parked for the whole window
         for (wait_cnt = 0; wait_cnt < 200; wait_cnt++) begin
            @(posedge axi4s_in0);
            assert (!valid_out_0 && !valid_out_1 && sop_mismatch) else
               stop_with_error("a first beat was let through while the packet ids differ");
         end
         assert (mismatch_count == 1) else stop_with_error($sformatf(
            "MISMATCH time %0t mismatch_count got %0d expected 1", $time, mismatch_count));
      end
      // half a cycle more so the bound checks of the last edge have run
      @(negedge axi4s_in0);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: stream_sync.f
verilog/stream_sync_pkg.sv
verilog/sop_tracker.sv
verilog/sync_fsm.sv
verilog/sync_event_counter.sv
verilog/stream_gate.sv
verilog/stream_sync.sv
sim/stream_sync_assertions.sv
sim/stream_sync_tb.sv
